//--- common/sdram_pkg.sv
`default_nettype none

// bank geometry and the request/response records seen by the array
package sdram_pkg;

    localparam int bank_aw = 12;  // word address bits
    localparam int bank_dw = 16;  // word width
    localparam int bank_mw = bank_dw / 8;  // one mask bit per byte

    // one access presented to the bank on the start cycle
    typedef struct packed {
        logic [bank_aw-1:0] addr;
        logic [bank_dw-1:0] data;  // write data, ignored on reads
        logic [bank_mw-1:0] mask;  // upper bit selects bits 15:8
        logic               we;
    } bank_req_t;

    // registered read word, held until the next access
    typedef struct packed {
        logic [bank_dw-1:0] data;
    } bank_rsp_t;

endpackage

`default_nettype wire

//--- common/rom_map_pkg.sv
`default_nettype none

// layout of the downloaded ROM image and where each region lands in the bank
package rom_map_pkg;

    import sdram_pkg::*;

    localparam int ioctl_aw = 16;  // host byte address width

    // first byte of the image picks one of these
    localparam logic [7:0] game_default = 8'd0;
    localparam logic [7:0] game_alt     = 8'd1;

    // region lengths in bytes
    localparam logic [15:0] cpu_len_default = 16'd2048;
    localparam logic [15:0] pcm_len_default = 16'd1024;
    localparam logic [15:0] cpu_len_alt     = 16'd1024;
    localparam logic [15:0] pcm_len_alt     = 16'd2048;

    localparam logic [ioctl_aw-1:0] rom_base = 16'd1;  // cpu region, pcm follows it

    // word offsets of the regions inside the bank
    localparam logic [bank_aw-1:0] cpu_word_offs = bank_aw'(0);
    localparam logic [bank_aw-1:0] pcm_word_offs = bank_aw'(1024);

    // one byte write from the loader, byte copied into both halves
    typedef struct packed {
        logic [bank_aw-1:0] addr;
        logic [bank_dw-1:0] data;
        logic [bank_mw-1:0] mask;  // 2'b10 even offset, 2'b01 odd offset
    } prog_wr_t;

endpackage

`default_nettype wire

//--- src/rom_loader.sv
`timescale 1ns/1ps
`default_nettype none

module rom_loader
    import sdram_pkg::*;
    import rom_map_pkg::*;
(
    input  wire logic                CLK,
    input  wire logic                rst,
    input  wire logic [ioctl_aw-1:0] ioctl_addr,
    input  wire logic [7:0]          ioctl_dout,
    input  wire logic                ioctl_wr,
    output prog_wr_t                 prog,
    output logic                     prog_we,
    input  wire logic                prog_rdy,
    output logic [7:0]               game
);

    logic [15:0]         cpu_len;
    logic [15:0]         pcm_len;
    logic [ioctl_aw-1:0] pcm_base;
    logic [ioctl_aw-1:0] rom_end;
    logic                is_game;
    logic                is_cpu;
    logic                is_pcm;
    logic [ioctl_aw-1:0] reg_offs;
    logic [bank_aw-1:0]  word_addr;

    // region bounds follow the layout latched from byte 0
    assign cpu_len  = (game == game_alt) ? cpu_len_alt : cpu_len_default;
    assign pcm_len  = (game == game_alt) ? pcm_len_alt : pcm_len_default;
    assign pcm_base = rom_base + cpu_len;
    assign rom_end  = pcm_base + pcm_len;

    assign is_game = ioctl_addr == '0;
    assign is_cpu  = ioctl_addr >= rom_base && ioctl_addr < pcm_base;
    assign is_pcm  = ioctl_addr >= pcm_base && ioctl_addr < rom_end;

    // byte offset inside its own region
    assign reg_offs  = is_cpu ? ioctl_addr - rom_base : ioctl_addr - pcm_base;
    assign word_addr = reg_offs[bank_aw:1] + (is_cpu ? cpu_word_offs : pcm_word_offs);

    always_ff @(posedge CLK) begin
        if (rst) begin
            prog_we <= 1'b0;
            game    <= game_default;
        end else if (ioctl_wr) begin
            if (is_game)
                game <= ioctl_dout;  // layout byte, never written to the bank
            else if (is_cpu || is_pcm)
                prog_we <= 1'b1;
        end else if (prog_rdy) begin
            prog_we <= 1'b0;
        end
    end

    // write payload, bytes past the pcm end are dropped
    always_ff @(posedge CLK) begin
        if (ioctl_wr && (is_cpu || is_pcm)) begin
            prog.addr <= word_addr;
            prog.data <= {2{ioctl_dout}};
            prog.mask <= reg_offs[0] ? 2'b01 : 2'b10;  // even byte goes high
        end
    end

    // host spacing must cover the whole bank write
    a_no_overrun: assert property (@(posedge CLK) disable iff (rst)
        ioctl_wr |-> !prog_we || prog_rdy)
        else $error("download byte arrived while a bank write was pending");

endmodule

`default_nettype wire

//--- sdram/sdram_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_timer #(
    parameter int LAT = 3
) (
    input  wire logic CLK,
    input  wire logic rst,
    input  wire logic start,
    output logic      done,
    output logic      busy
);

    localparam int cw = $clog2(LAT + 1);

    logic [cw-1:0] cnt;

    always_ff @(posedge CLK) begin
        if (rst)
            cnt <= '0;
        else if (start)
            cnt <= cw'(LAT);
        else if (cnt != '0)
            cnt <= cnt - 1'b1;
    end

    assign done = cnt == cw'(1);  // LAT cycles after start
    assign busy = cnt != '0;

    a_no_restart: assert property (@(posedge CLK) disable iff (rst)
        start |-> !busy)
        else $error("access started while the previous one was running");

endmodule

`default_nettype wire

//--- sdram/sdram_array.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_array
    import sdram_pkg::*;
#(
    parameter int AW    = bank_aw,
    parameter int DEPTH = 1 << AW
) (
    input  wire logic      CLK,
    input  wire bank_req_t req,
    input  wire logic      en,
    output bank_rsp_t      rsp
);

    logic [bank_dw-1:0] mem [DEPTH];
    logic [AW-1:0]      waddr;

    assign waddr = req.addr[AW-1:0];

    always_ff @(posedge CLK) begin
        if (en) begin
            if (req.we) begin
                if (req.mask[1])
                    mem[waddr][15:8] <= req.data[15:8];
                if (req.mask[0])
                    mem[waddr][7:0] <= req.data[7:0];
            end else begin
                rsp.data <= mem[waddr];  // stays put until the next read
            end
        end
    end

    a_mask_set: assert property (@(posedge CLK)
        en && req.we |-> req.mask != '0)
        else $error("bank write with no byte enabled");

endmodule

`default_nettype wire

//--- sdram/sdram_sched.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_sched
    import sdram_pkg::*;
    import rom_map_pkg::*;
#(
    parameter int AW = bank_aw
) (
    input  wire logic          CLK,
    input  wire logic          rst,
    input  wire logic          downloading,
    input  wire prog_wr_t      prog,
    input  wire logic          prog_we,
    output logic               prog_rdy,
    input  wire logic [1:0]    rd_req,
    input  wire logic [AW-1:0] rd_addr0,
    input  wire logic [AW-1:0] rd_addr1,
    output logic [1:0]         rd_done,
    output logic               start,
    input  wire logic          done,
    output bank_req_t          bank_req
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_finish
    } state_e;

    typedef enum logic [1:0] {
        own_prog,
        own_rd0,
        own_rd1
    } owner_e;

    state_e state;
    owner_e owner;  // who holds the bank for this access
    owner_e pick;
    logic   req_any;

    // loader alone during download and cpu ahead of pcm after it
    always_comb begin
        req_any = 1'b1;
        pick    = own_prog;
        if (downloading)
            req_any = prog_we;
        else if (rd_req[0])
            pick = own_rd0;
        else if (rd_req[1])
            pick = own_rd1;
        else
            req_any = 1'b0;
    end

    assign start = (state == st_idle) && req_any;

    // only sampled by the array on the start cycle
    always_comb begin
        case (pick)
            own_prog: bank_req = '{addr: prog.addr, data: prog.data, mask: prog.mask, we: 1'b1};
            own_rd0:  bank_req = '{addr: bank_aw'(rd_addr0), data: '0, mask: '0, we: 1'b0};
            default:  bank_req = '{addr: bank_aw'(rd_addr1), data: '0, mask: '0, we: 1'b0};
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= st_idle;
            owner <= own_prog;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_busy;
                        owner <= pick;
                    end
                end
                st_busy: begin
                    if (done)
                        state <= st_finish;  // read word already registered
                end
                st_finish: state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    assign prog_rdy   = (state == st_finish) && (owner == own_prog);
    assign rd_done[0] = (state == st_finish) && (owner == own_rd0);
    assign rd_done[1] = (state == st_finish) && (owner == own_rd1);

    // a timer completion has to land on the access that is waiting for it
    a_done_busy: assert property (@(posedge CLK) disable iff (rst)
        done |-> state == st_busy)
        else $error("latency timer finished while no access was running");

endmodule

`default_nettype wire

//--- src/rom_slot.sv
`timescale 1ns/1ps
`default_nettype none

module rom_slot
    import sdram_pkg::*;
    import rom_map_pkg::*;
#(
    parameter type payload_t = logic [15:0],
    parameter int  AW        = bank_aw
) (
    input  wire logic          CLK,
    input  wire logic          rst,
    input  wire logic          cs,
    input  wire logic [AW-1:0] addr,
    output logic               ok,
    output payload_t           dout,
    output logic               rd_req,
    output logic [AW-1:0]      rd_addr,
    input  wire logic          rd_done,
    input  wire bank_rsp_t     rd_data
);

    // byte clients address bytes and live in the pcm region
    localparam bit byte_mode = $bits(payload_t) == 8;
    localparam logic [AW-1:0] word_offs = byte_mode ? AW'(pcm_word_offs) : AW'(cpu_word_offs);

    logic [AW-1:0]      want_addr;
    logic [AW-1:0]      tag;
    logic [bank_dw-1:0] word;
    logic               valid;
    logic               hit;
    logic [bank_dw-1:0] sel;

    assign want_addr = (byte_mode ? addr >> 1 : addr) + word_offs;
    assign hit       = valid && tag == want_addr;
    assign ok        = hit;  // follows addr in the same cycle

    always_comb begin
        if (!byte_mode)
            sel = word;
        else if (addr[0])
            sel = {8'h00, word[7:0]};  // odd byte in the low half
        else
            sel = {8'h00, word[15:8]};
    end

    assign dout = payload_t'(sel);

    always_ff @(posedge CLK) begin
        if (rst) begin
            valid  <= 1'b0;
            rd_req <= 1'b0;
        end else if (rd_done) begin
            valid  <= 1'b1;
            rd_req <= 1'b0;
        end else if (cs && !hit && !rd_req) begin
            rd_req <= 1'b1;  // held until the scheduler grants it
        end
    end

    // request address and cached word
    always_ff @(posedge CLK) begin
        if (cs && !hit && !rd_req && !rd_done)
            rd_addr <= want_addr;
        if (rd_done) begin
            word <= rd_data.data;
            tag  <= rd_addr;  // an addr change while waiting just misses again
        end
    end

    a_done_pending: assert property (@(posedge CLK) disable iff (rst)
        rd_done |-> rd_req)
        else $error("read completion without a pending request");

endmodule

`default_nettype wire

//--- src/rom_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module rom_subsys_top
    import sdram_pkg::*;
    import rom_map_pkg::*;
#(
    parameter int AW  = bank_aw,
    parameter int LAT = 3
) (
    input  wire logic                CLK,
    input  wire logic                rst,
    // host download
    input  wire logic [ioctl_aw-1:0] ioctl_addr,
    input  wire logic [7:0]          ioctl_dout,
    input  wire logic                ioctl_wr,
    input  wire logic                downloading,
    output logic [7:0]               game,
    // cpu program, word addressed
    input  wire logic                cpu_cs,
    input  wire logic [AW-1:0]       cpu_addr,
    output logic                     cpu_ok,
    output logic [15:0]              cpu_dout,
    // pcm samples, byte addressed
    input  wire logic                pcm_cs,
    input  wire logic [AW-1:0]       pcm_addr,
    output logic                     pcm_ok,
    output logic [7:0]               pcm_dout
);

    prog_wr_t      prog;
    logic          prog_we;
    logic          prog_rdy;
    logic [1:0]    rd_req;
    logic [1:0]    rd_done;
    logic [AW-1:0] rd_addr0;
    logic [AW-1:0] rd_addr1;
    logic          start;
    logic          done;
    bank_req_t     bank_req;
    bank_rsp_t     bank_rsp;

    rom_loader rom_loader_i (
        .CLK        (CLK),
        .rst        (rst),
        .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout),
        .ioctl_wr   (ioctl_wr),
        .prog       (prog),
        .prog_we    (prog_we),
        .prog_rdy   (prog_rdy),
        .game       (game)
    );

    sdram_sched #(.AW(AW)) sdram_sched_i (
        .CLK         (CLK),
        .rst         (rst),
        .downloading (downloading),
        .prog        (prog),
        .prog_we     (prog_we),
        .prog_rdy    (prog_rdy),
        .rd_req      (rd_req),
        .rd_addr0    (rd_addr0),
        .rd_addr1    (rd_addr1),
        .rd_done     (rd_done),
        .start       (start),
        .done        (done),
        .bank_req    (bank_req)
    );

    sdram_timer #(.LAT(LAT)) sdram_timer_i (
        .CLK   (CLK),
        .rst   (rst),
        .start (start),
        .done  (done),
        .busy  ()
    );

    sdram_array #(.AW(AW), .DEPTH(1 << AW)) sdram_array_i (
        .CLK (CLK),
        .req (bank_req),
        .en  (start),
        .rsp (bank_rsp)
    );

    rom_slot #(.payload_t(logic [15:0]), .AW(AW)) cpu_slot_i (
        .CLK     (CLK),
        .rst     (rst),
        .cs      (cpu_cs),
        .addr    (cpu_addr),
        .ok      (cpu_ok),
        .dout    (cpu_dout),
        .rd_req  (rd_req[0]),
        .rd_addr (rd_addr0),
        .rd_done (rd_done[0]),
        .rd_data (bank_rsp)
    );

    rom_slot #(.payload_t(logic [7:0]), .AW(AW)) pcm_slot_i (
        .CLK     (CLK),
        .rst     (rst),
        .cs      (pcm_cs),
        .addr    (pcm_addr),
        .ok      (pcm_ok),
        .dout    (pcm_dout),
        .rd_req  (rd_req[1]),
        .rd_addr (rd_addr1),
        .rd_done (rd_done[1]),
        .rd_data (bank_rsp)
    );

endmodule

`default_nettype wire

//--- test/rom_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rom_checker #(
    parameter int AW = 12
) (
    input  wire logic          CLK,
    input  wire logic          rst,
    // cpu client and its expected word
    input  wire logic          cpu_cs,
    input  wire logic [AW-1:0] cpu_addr,
    input  wire logic          cpu_ok,
    input  wire logic [15:0]   cpu_dout,
    input  wire logic [15:0]   cpu_exp,
    // pcm client and its expected byte
    input  wire logic          pcm_cs,
    input  wire logic [AW-1:0] pcm_addr,
    input  wire logic          pcm_ok,
    input  wire logic [7:0]    pcm_dout,
    input  wire logic [7:0]    pcm_exp,
    // layout byte
    input  wire logic [7:0]    game,
    input  wire logic [7:0]    game_exp,
    input  wire logic          game_chk,
    // forced ok level, bit 0 cpu, bit 1 pcm
    input  wire logic [1:0]    ok_chk_en,
    input  wire logic [1:0]    ok_chk_val,
    output int                 err_cnt
);

    int   cpu_errs;
    int   pcm_errs;
    int   game_errs;
    logic cpu_bad;
    logic cpu_ok_bad;
    logic pcm_bad;
    logic pcm_ok_bad;
    logic game_bad;

    // data only counts once the slot claims a hit
    assign cpu_bad    = cpu_cs && cpu_ok && (cpu_dout !== cpu_exp);
    assign cpu_ok_bad = ok_chk_en[0] && (cpu_ok !== ok_chk_val[0]);
    assign pcm_bad    = pcm_cs && pcm_ok && (pcm_dout !== pcm_exp);
    assign pcm_ok_bad = ok_chk_en[1] && (pcm_ok !== ok_chk_val[1]);
    assign game_bad   = game_chk && (game !== game_exp);

    always_ff @(posedge CLK) begin
        if (rst) begin
            cpu_errs <= 0;
        end else begin
            if (cpu_bad)
                $display("Fail %0t: cpu word %0h read %h, expected %h",
                         $time, cpu_addr, cpu_dout, cpu_exp);
            if (cpu_ok_bad)
                $display("Fail %0t: cpu_ok is %b at word %0h, expected %b",
                         $time, cpu_ok, cpu_addr, ok_chk_val[0]);
            cpu_errs <= cpu_errs + int'(cpu_bad) + int'(cpu_ok_bad);
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            pcm_errs <= 0;
        end else begin
            if (pcm_bad)
                $display("Fail %0t: pcm byte %0h read %h, expected %h",
                         $time, pcm_addr, pcm_dout, pcm_exp);
            if (pcm_ok_bad)
                $display("Fail %0t: pcm_ok is %b at byte %0h, expected %b",
                         $time, pcm_ok, pcm_addr, ok_chk_val[1]);
            pcm_errs <= pcm_errs + int'(pcm_bad) + int'(pcm_ok_bad);
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            game_errs <= 0;
        end else if (game_bad) begin
            $display("Fail %0t: game is %h, expected %h", $time, game, game_exp);
            game_errs <= game_errs + 1;
        end
    end

    assign err_cnt = cpu_errs + pcm_errs + game_errs;

endmodule

`default_nettype wire

//--- test/tb_rom_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rom_subsys
    import sdram_pkg::*;
    import rom_map_pkg::*;
();

    localparam int AW         = bank_aw;
    localparam int LAT        = 3;
    localparam int n_unmapped = 16;  // junk bytes past the pcm end
    localparam int n_cpu      = 40;
    localparam int n_pcm      = 40;
    localparam int n_conc     = 24;  // reads per client in the overlap phase
    localparam int image_max  = 1 + 2048 + 1024 + n_unmapped;
    localparam int n_reads    = n_cpu + n_pcm + 2 * n_conc + 8;
    localparam int wait_lim   = 4 * (LAT + 2);
    localparam int cycle_lim  = image_max * 8 + n_reads * wait_lim + 2000;

    logic                CLK;
    logic                rst;
    logic [ioctl_aw-1:0] ioctl_addr;
    logic [7:0]          ioctl_dout;
    logic                ioctl_wr;
    logic                downloading;
    logic [7:0]          game;
    logic                cpu_cs;
    logic [AW-1:0]       cpu_addr;
    logic                cpu_ok;
    logic [15:0]         cpu_dout;
    logic                pcm_cs;
    logic [AW-1:0]       pcm_addr;
    logic                pcm_ok;
    logic [7:0]          pcm_dout;

    // expectations handed to the checker
    logic [15:0] cpu_exp;
    logic [7:0]  pcm_exp;
    logic [7:0]  game_exp;
    logic        game_chk;
    logic [1:0]  ok_chk_en;
    logic [1:0]  ok_chk_val;

    int         err_cnt;
    int         timeouts = 0;
    int         cycles = 0;
    logic [7:0] image [image_max];  // model of the downloaded bytes
    int         cpu_len;
    int         pcm_len;
    int         image_len;

    rom_subsys_top #(.AW(AW), .LAT(LAT)) rom_subsys_top_i (
        .CLK         (CLK),
        .rst         (rst),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .downloading (downloading),
        .game        (game),
        .cpu_cs      (cpu_cs),
        .cpu_addr    (cpu_addr),
        .cpu_ok      (cpu_ok),
        .cpu_dout    (cpu_dout),
        .pcm_cs      (pcm_cs),
        .pcm_addr    (pcm_addr),
        .pcm_ok      (pcm_ok),
        .pcm_dout    (pcm_dout)
    );

    rom_checker #(.AW(AW)) rom_checker_i (
        .CLK        (CLK),
        .rst        (rst),
        .cpu_cs     (cpu_cs),
        .cpu_addr   (cpu_addr),
        .cpu_ok     (cpu_ok),
        .cpu_dout   (cpu_dout),
        .cpu_exp    (cpu_exp),
        .pcm_cs     (pcm_cs),
        .pcm_addr   (pcm_addr),
        .pcm_ok     (pcm_ok),
        .pcm_dout   (pcm_dout),
        .pcm_exp    (pcm_exp),
        .game       (game),
        .game_exp   (game_exp),
        .game_chk   (game_chk),
        .ok_chk_en  (ok_chk_en),
        .ok_chk_val (ok_chk_val),
        .err_cnt    (err_cnt)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_lim) begin
            $display("run stopped after %0d cycles without reaching the end", cycles);
            $display("errors %0d, timeouts %0d", err_cnt, timeouts);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // even byte of the region goes high, next odd byte low
    function automatic logic [15:0] cpu_word(input int a);
        int base;
        base = int'(rom_base) + 2 * a;
        return {image[base], image[base + 1]};
    endfunction

    function automatic logic [7:0] pcm_byte(input int p);
        return image[int'(rom_base) + cpu_len + p];
    endfunction

    task automatic send_byte(input int a, input logic [7:0] d);
        @(negedge CLK);
        ioctl_addr = ioctl_aw'(a);
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        image[a]   = d;
        @(negedge CLK);
        ioctl_wr = 1'b0;
        repeat (6) @(negedge CLK);  // strobes 8 cycles apart
    endtask

    task automatic download();
        logic [7:0] g;
        g = ($urandom_range(0, 1) == 1) ? game_alt : game_default;
        cpu_len   = (g == game_alt) ? int'(cpu_len_alt) : int'(cpu_len_default);
        pcm_len   = (g == game_alt) ? int'(pcm_len_alt) : int'(pcm_len_default);
        image_len = 1 + cpu_len + pcm_len + n_unmapped;
        @(negedge CLK);
        downloading = 1'b1;
        send_byte(0, g);
        for (int i = 1; i < image_len; i++)
            send_byte(i, 8'($urandom));
        downloading = 1'b0;
        game_exp    = g;
        game_chk    = 1'b1;
    endtask

    task automatic wait_cpu_ok();
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!cpu_ok && n < wait_lim);
        if (!cpu_ok) begin
            timeouts++;
            $display("cpu read of word %0h never completed", cpu_addr);
        end
    endtask

    task automatic wait_pcm_ok();
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!pcm_ok && n < wait_lim);
        if (!pcm_ok) begin
            timeouts++;
            $display("pcm read of byte %0h never completed", pcm_addr);
        end
    endtask

    task automatic read_cpu(input int a);
        @(negedge CLK);
        cpu_cs   = 1'b1;
        cpu_addr = AW'(a);
        cpu_exp  = cpu_word(a);
        wait_cpu_ok();
    endtask

    task automatic read_pcm(input int p);
        @(negedge CLK);
        pcm_cs   = 1'b1;
        pcm_addr = AW'(p);
        pcm_exp  = pcm_byte(p);
        wait_pcm_ok();
    endtask

    task automatic hit_and_miss();
        int a;
        int p;
        a = $urandom_range(0, cpu_len / 2 - 1);
        read_cpu(a);
        ok_chk_en[0]  = 1'b1;  // held address stays a hit
        ok_chk_val[0] = 1'b1;
        repeat (3) @(negedge CLK);
        cpu_addr      = AW'(a ^ 1);  // neighbouring word, miss at once
        cpu_exp       = cpu_word(a ^ 1);
        ok_chk_val[0] = 1'b0;
        @(negedge CLK);
        ok_chk_en[0] = 1'b0;
        wait_cpu_ok();

        p = 2 * $urandom_range(0, pcm_len / 2 - 1);
        read_pcm(p);
        ok_chk_en[1]  = 1'b1;
        ok_chk_val[1] = 1'b1;
        @(negedge CLK);
        pcm_addr = AW'(p + 1);  // other half of the cached word
        pcm_exp  = pcm_byte(p + 1);
        repeat (2) @(negedge CLK);
        ok_chk_en[1] = 1'b0;
    endtask

    task automatic overlapping_reads();
        fork
            for (int i = 0; i < n_conc; i++) begin
                repeat ($urandom_range(0, 3)) @(negedge CLK);
                read_cpu($urandom_range(0, cpu_len / 2 - 1));
            end
            for (int j = 0; j < n_conc; j++) begin
                repeat ($urandom_range(0, 3)) @(negedge CLK);
                read_pcm($urandom_range(0, pcm_len - 1));
            end
        join
    endtask

    initial begin
        void'($urandom(32'hae663d86));
        CLK         = 1'b0;
        rst         = 1'b1;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        downloading = 1'b0;
        cpu_cs      = 1'b0;
        cpu_addr    = '0;
        pcm_cs      = 1'b0;
        pcm_addr    = '0;
        cpu_exp     = '0;
        pcm_exp     = '0;
        game_exp    = '0;
        game_chk    = 1'b0;
        ok_chk_en   = '0;
        ok_chk_val  = '0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;

        download();
        repeat (4) @(negedge CLK);
        for (int i = 0; i < n_cpu; i++)
            read_cpu($urandom_range(0, cpu_len / 2 - 1));
        for (int i = 0; i < n_pcm; i++)
            read_pcm($urandom_range(0, pcm_len - 1));
        hit_and_miss();
        overlapping_reads();
        repeat (4) @(negedge CLK);

        $display("errors %0d, timeouts %0d", err_cnt, timeouts);
        if (err_cnt == 0 && timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
common/sdram_pkg.sv
common/rom_map_pkg.sv
src/rom_loader.sv
sdram/sdram_timer.sv
sdram/sdram_array.sv
sdram/sdram_sched.sv
src/rom_slot.sv
src/rom_subsys_top.sv
test/rom_checker.sv
test/tb_rom_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_rom_subsys -o sim_rom_subsys > build.log 2>&1 \
    && ./obj_dir/sim_rom_subsys > sim.log 2>&1 \
    || { cat build.log; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1
